// ==== design/isa_pkg.sv ====
package isa_pkg;

    localparam int INST_W  = 32;
    localparam int OP_W    = 6;
    localparam int RF_AW   = 5;
    localparam int SHAMT_W = 5;
    localparam int FUNCT_W = 6;
    localparam int IMM_W   = 16;

    // major opcodes, bits 31:26
    typedef enum logic [OP_W-1:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } op_e;

    // function field of SPECIAL words
    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_MOVZ = 6'b001010,
        FN_MOVN = 6'b001011,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef struct packed {
        logic [OP_W-1:0]    op;
        logic [RF_AW-1:0]   rs;
        logic [RF_AW-1:0]   rt;
        logic [RF_AW-1:0]   rd;
        logic [SHAMT_W-1:0] shamt;
        logic [FUNCT_W-1:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [OP_W-1:0]  op;
        logic [RF_AW-1:0] rs;
        logic [RF_AW-1:0] rt;
        logic [IMM_W-1:0] imm16;
    } i_fmt_t;

    // same 32 bits, register or immediate view
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } inst_u;

endpackage

// ==== design/pipe_pkg.sv ====
package pipe_pkg;

    localparam int DATA_W   = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [DATA_W-1:0] word_t;

    // operation code handed to execute
    typedef enum logic [7:0] {
        ALU_NOP   = 8'b00000000,
        ALU_AND   = 8'b00100100,
        ALU_OR    = 8'b00100101,
        ALU_XOR   = 8'b00100110,
        ALU_NOR   = 8'b00100111,
        ALU_SLL   = 8'b01111100,
        ALU_SRL   = 8'b00000010,
        ALU_SRA   = 8'b00000011,
        ALU_SLT   = 8'b00101010,
        ALU_SLTU  = 8'b00101011,
        ALU_ADD   = 8'b00100000,
        ALU_ADDU  = 8'b00100001,
        ALU_SUB   = 8'b00100010,
        ALU_SUBU  = 8'b00100011,
        ALU_ADDI  = 8'b01010101,
        ALU_ADDIU = 8'b01010110,
        ALU_MOVZ  = 8'b00001010,
        ALU_MOVN  = 8'b00001011
    } aluop_e;

    // result class, picks the execute result mux
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100
    } alusel_e;

    typedef enum logic [1:0] {
        WR_NONE       = 2'b00,
        WR_ALWAYS     = 2'b01,
        WR_IF_ZERO    = 2'b10,  // movz
        WR_IF_NONZERO = 2'b11   // movn
    } wr_mode_e;

endpackage

// ==== design/rf_read_if.sv ====
`timescale 1ns/1ps

interface rf_read_if;
    import pipe_pkg::*;

    logic      re_1;
    reg_addr_t addr_1;
    word_t     data_1;
    logic      re_2;
    reg_addr_t addr_2;
    word_t     data_2;

    modport master (output re_1, addr_1, re_2, addr_2,
                    input  data_1, data_2);
    modport slave (input  re_1, addr_1, re_2, addr_2,
                   output data_1, data_2);
    modport monitor (input re_1, addr_1, data_1,
                     input re_2, addr_2, data_2);
endinterface

// ==== design/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                clk_i,
    input  logic                rst_n_i,
    rf_read_if.slave            rd,
    input  logic                we_i,
    input  pipe_pkg::reg_addr_t waddr_i,
    input  pipe_pkg::word_t     wdata_i
);
    import pipe_pkg::*;

    word_t regs [NUM_REGS];
    logic  wr_en;

    assign wr_en = we_i && (waddr_i != '0);  // r0 is hardwired

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    function automatic word_t read_port(
        input logic      re,
        input reg_addr_t addr,
        input logic      wen,
        input reg_addr_t waddr,
        input word_t     wdata
    );
        if (!re || addr == '0) begin
            return '0;
        end else if (wen && waddr == addr) begin
            return wdata;  // write-through
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd.data_1 = read_port(rd.re_1, rd.addr_1, wr_en, waddr_i, wdata_i);
        rd.data_2 = read_port(rd.re_2, rd.addr_2, wr_en, waddr_i, wdata_i);
    end

    a_r0_reads_zero: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (rd.addr_1 == '0) |-> (rd.data_1 == '0)
    ) else $error("regfile: port 1 returned nonzero data for r0");

endmodule

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  isa_pkg::inst_u      inst_i,
    rf_read_if.master           rd,
    output pipe_pkg::aluop_e    aluop_o,
    output pipe_pkg::alusel_e   alusel_o,
    output pipe_pkg::reg_addr_t wd_o,
    output pipe_pkg::wr_mode_e  wr_mode_o,
    output pipe_pkg::word_t     imm_o,
    output logic                invalid_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [INST_W-1:0] inst_raw;
    logic [IMM_W-1:0]  imm16;
    word_t             imm_zext;
    word_t             imm_sext;
    word_t             imm_upper;
    word_t             imm_shamt;
    logic              fixed_ok;
    logic              shamt_zero;
    logic              fn_fixed;
    aluop_e            fn_aluop;
    alusel_e           fn_sel;
    logic              itype;
    logic              re_1;
    logic              re_2;

    assign inst_raw   = inst_i;
    assign imm16      = inst_i.i_fmt.imm16;
    assign imm_zext   = {{(DATA_W-IMM_W){1'b0}}, imm16};
    assign imm_sext   = {{(DATA_W-IMM_W){imm16[IMM_W-1]}}, imm16};
    assign imm_upper  = {imm16, {(DATA_W-IMM_W){1'b0}}};  // lui
    assign imm_shamt  = {{(DATA_W-SHAMT_W){1'b0}}, inst_i.r_fmt.shamt};

    // fixed shifts need op and rs all zero, the rest need shamt zero
    assign fixed_ok   = (inst_raw[INST_W-1 -: OP_W+RF_AW] == '0);
    assign shamt_zero = (inst_i.r_fmt.shamt == '0);
    assign fn_fixed   = inst_i.r_fmt.funct inside {FN_SLL, FN_SRL, FN_SRA};

    // sources are always rs and rt, only the enables change
    assign rd.addr_1 = inst_i.r_fmt.rs;
    assign rd.addr_2 = inst_i.r_fmt.rt;
    assign rd.re_1   = re_1;
    assign rd.re_2   = re_2;

    // function field decode for SPECIAL words
    always_comb begin
        case (inst_i.r_fmt.funct)
            FN_AND, FN_OR, FN_XOR, FN_NOR:                      fn_sel = SEL_LOGIC;
            FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV:  fn_sel = SEL_SHIFT;
            FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU:  fn_sel = SEL_ARITH;
            FN_MOVZ, FN_MOVN:                                   fn_sel = SEL_MOVE;
            default:                                            fn_sel = SEL_NOP;
        endcase

        case (inst_i.r_fmt.funct)
            FN_AND:          fn_aluop = ALU_AND;
            FN_OR:           fn_aluop = ALU_OR;
            FN_XOR:          fn_aluop = ALU_XOR;
            FN_NOR:          fn_aluop = ALU_NOR;
            FN_SLL, FN_SLLV: fn_aluop = ALU_SLL;
            FN_SRL, FN_SRLV: fn_aluop = ALU_SRL;
            FN_SRA, FN_SRAV: fn_aluop = ALU_SRA;
            FN_ADD:          fn_aluop = ALU_ADD;
            FN_ADDU:         fn_aluop = ALU_ADDU;
            FN_SUB:          fn_aluop = ALU_SUB;
            FN_SUBU:         fn_aluop = ALU_SUBU;
            FN_SLT:          fn_aluop = ALU_SLT;
            FN_SLTU:         fn_aluop = ALU_SLTU;
            FN_MOVZ:         fn_aluop = ALU_MOVZ;
            FN_MOVN:         fn_aluop = ALU_MOVN;
            default:         fn_aluop = ALU_NOP;
        endcase
    end

    always_comb begin
        aluop_o   = ALU_NOP;
        alusel_o  = SEL_NOP;
        wd_o      = inst_i.r_fmt.rd;
        wr_mode_o = WR_NONE;
        imm_o     = '0;
        re_1      = 1'b0;
        re_2      = 1'b0;
        invalid_o = 1'b1;
        itype     = 1'b0;

        case (inst_i.i_fmt.op)
            OP_SPECIAL: begin
                if (fn_sel != SEL_NOP && (fn_fixed ? fixed_ok : shamt_zero)) begin
                    invalid_o = 1'b0;
                    aluop_o   = fn_aluop;
                    alusel_o  = fn_sel;
                    re_1      = !fn_fixed;  // shamt takes port 1 slot
                    re_2      = 1'b1;
                    imm_o     = fn_fixed ? imm_shamt : '0;
                    case (inst_i.r_fmt.funct)
                        FN_MOVZ: wr_mode_o = WR_IF_ZERO;
                        FN_MOVN: wr_mode_o = WR_IF_NONZERO;
                        default: wr_mode_o = WR_ALWAYS;
                    endcase
                end
            end
            OP_ANDI: begin
                itype    = 1'b1;
                aluop_o  = ALU_AND;
                alusel_o = SEL_LOGIC;
                imm_o    = imm_zext;
            end
            OP_ORI: begin
                itype    = 1'b1;
                aluop_o  = ALU_OR;
                alusel_o = SEL_LOGIC;
                imm_o    = imm_zext;
            end
            OP_XORI: begin
                itype    = 1'b1;
                aluop_o  = ALU_XOR;
                alusel_o = SEL_LOGIC;
                imm_o    = imm_zext;
            end
            OP_LUI: begin
                itype    = 1'b1;
                aluop_o  = ALU_OR;  // rs | (imm << 16)
                alusel_o = SEL_LOGIC;
                imm_o    = imm_upper;
            end
            OP_SLTI: begin
                itype    = 1'b1;
                aluop_o  = ALU_SLT;
                alusel_o = SEL_ARITH;
                imm_o    = imm_sext;
            end
            OP_SLTIU: begin
                itype    = 1'b1;
                aluop_o  = ALU_SLTU;
                alusel_o = SEL_ARITH;
                imm_o    = imm_zext;
            end
            OP_ADDI: begin
                itype    = 1'b1;
                aluop_o  = ALU_ADDI;
                alusel_o = SEL_ARITH;
                imm_o    = imm_sext;
            end
            OP_ADDIU: begin
                itype    = 1'b1;
                aluop_o  = ALU_ADDIU;
                alusel_o = SEL_ARITH;
                imm_o    = imm_sext;
            end
            default: invalid_o = 1'b1;  // dropped or unknown opcode
        endcase

        if (itype) begin
            wd_o      = inst_i.i_fmt.rt;
            wr_mode_o = WR_ALWAYS;
            re_1      = 1'b1;
            invalid_o = 1'b0;
        end
    end

    a_invalid_no_read: assert final (!invalid_o || (!rd.re_1 && !rd.re_2))
        else $error("inst_decoder: invalid word enabled a register read");

endmodule

// ==== design/operand_fwd.sv ====
`timescale 1ns/1ps

module operand_fwd (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                valid_i,
    rf_read_if.monitor          rd,
    input  pipe_pkg::aluop_e    aluop_i,
    input  pipe_pkg::alusel_e   alusel_i,
    input  pipe_pkg::reg_addr_t wd_i,
    input  pipe_pkg::wr_mode_e  wr_mode_i,
    input  pipe_pkg::word_t     imm_i,
    input  logic                invalid_i,
    input  logic                ex_wreg_i,
    input  pipe_pkg::reg_addr_t ex_wd_i,
    input  pipe_pkg::word_t     ex_wdata_i,
    input  logic                mem_wreg_i,
    input  pipe_pkg::reg_addr_t mem_wd_i,
    input  pipe_pkg::word_t     mem_wdata_i,
    output logic                out_valid_o,
    output pipe_pkg::aluop_e    aluop_o,
    output pipe_pkg::alusel_e   alusel_o,
    output pipe_pkg::word_t     reg1_o,
    output pipe_pkg::word_t     reg2_o,
    output pipe_pkg::reg_addr_t wd_o,
    output logic                wreg_o,
    output logic                inst_invalid_o
);
    import pipe_pkg::*;

    word_t reg1_d;
    word_t reg2_d;
    logic  wreg_d;

    // ex result is newest, so it wins over mem
    function automatic word_t pick_operand(
        input logic      re,
        input reg_addr_t addr,
        input word_t     rf_data,
        input word_t     imm,
        input logic      ex_we,
        input reg_addr_t ex_addr,
        input word_t     ex_data,
        input logic      mem_we,
        input reg_addr_t mem_addr,
        input word_t     mem_data
    );
        if (!re) begin
            return imm;
        end else if (ex_we && ex_addr == addr && addr != '0) begin
            return ex_data;
        end else if (mem_we && mem_addr == addr && addr != '0) begin
            return mem_data;
        end
        return rf_data;
    endfunction

    always_comb begin
        reg1_d = pick_operand(rd.re_1, rd.addr_1, rd.data_1, imm_i, ex_wreg_i, ex_wd_i,
                              ex_wdata_i, mem_wreg_i, mem_wd_i, mem_wdata_i);
        reg2_d = pick_operand(rd.re_2, rd.addr_2, rd.data_2, imm_i, ex_wreg_i, ex_wd_i,
                              ex_wdata_i, mem_wreg_i, mem_wd_i, mem_wdata_i);

        case (wr_mode_i)
            WR_ALWAYS:     wreg_d = 1'b1;
            WR_IF_ZERO:    wreg_d = (reg2_d == '0);
            WR_IF_NONZERO: wreg_d = (reg2_d != '0);
            default:       wreg_d = 1'b0;
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_o    <= 1'b0;
            wreg_o         <= 1'b0;
            aluop_o        <= ALU_NOP;
            alusel_o       <= SEL_NOP;
            inst_invalid_o <= 1'b0;
        end else begin
            out_valid_o <= valid_i;
            if (valid_i) begin
                wreg_o         <= wreg_d;
                aluop_o        <= aluop_i;
                alusel_o       <= alusel_i;
                inst_invalid_o <= invalid_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            reg1_o <= reg1_d;
            reg2_o <= reg2_d;
            wd_o   <= wd_i;
        end
    end

    a_one_out_per_strobe: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (out_valid_o && $past(out_valid_o)) |-> ($past(valid_i) && $past(valid_i, 2))
    ) else $error("operand_fwd: out_valid_o held without back-to-back strobes");

endmodule

// ==== design/decode_top.sv ====
`timescale 1ns/1ps

module decode_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                inst_valid_i,
    input  isa_pkg::inst_u      inst_i,
    input  logic                wb_we_i,
    input  pipe_pkg::reg_addr_t wb_addr_i,
    input  pipe_pkg::word_t     wb_data_i,
    input  logic                ex_wreg_i,
    input  pipe_pkg::reg_addr_t ex_wd_i,
    input  pipe_pkg::word_t     ex_wdata_i,
    input  logic                mem_wreg_i,
    input  pipe_pkg::reg_addr_t mem_wd_i,
    input  pipe_pkg::word_t     mem_wdata_i,
    output logic                out_valid_o,
    output pipe_pkg::aluop_e    aluop_o,
    output pipe_pkg::alusel_e   alusel_o,
    output pipe_pkg::word_t     reg1_o,
    output pipe_pkg::word_t     reg2_o,
    output pipe_pkg::reg_addr_t wd_o,
    output logic                wreg_o,
    output logic                inst_invalid_o
);
    import pipe_pkg::*;

    aluop_e    dec_aluop;
    alusel_e   dec_alusel;
    reg_addr_t dec_wd;
    wr_mode_e  dec_wr_mode;
    word_t     dec_imm;
    logic      dec_invalid;

    rf_read_if rf_rd ();

    inst_decoder u_inst_decoder (
        .inst_i    (inst_i),
        .rd        (rf_rd.master),
        .aluop_o   (dec_aluop),
        .alusel_o  (dec_alusel),
        .wd_o      (dec_wd),
        .wr_mode_o (dec_wr_mode),
        .imm_o     (dec_imm),
        .invalid_o (dec_invalid)
    );

    regfile u_regfile (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .rd      (rf_rd.slave),
        .we_i    (wb_we_i),
        .waddr_i (wb_addr_i),
        .wdata_i (wb_data_i)
    );

    operand_fwd u_operand_fwd (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .valid_i        (inst_valid_i),
        .rd             (rf_rd.monitor),
        .aluop_i        (dec_aluop),
        .alusel_i       (dec_alusel),
        .wd_i           (dec_wd),
        .wr_mode_i      (dec_wr_mode),
        .imm_i          (dec_imm),
        .invalid_i      (dec_invalid),
        .ex_wreg_i      (ex_wreg_i),
        .ex_wd_i        (ex_wd_i),
        .ex_wdata_i     (ex_wdata_i),
        .mem_wreg_i     (mem_wreg_i),
        .mem_wd_i       (mem_wd_i),
        .mem_wdata_i    (mem_wdata_i),
        .out_valid_o    (out_valid_o),
        .aluop_o        (aluop_o),
        .alusel_o       (alusel_o),
        .reg1_o         (reg1_o),
        .reg2_o         (reg2_o),
        .wd_o           (wd_o),
        .wreg_o         (wreg_o),
        .inst_invalid_o (inst_invalid_o)
    );

endmodule

// ==== testbench/decode_model.svh ====
typedef struct packed {
    aluop_e   op;
    alusel_e  sel;
    wr_mode_e mode;
    logic     known;
} dec_t;

word_t       shadow_rf [NUM_REGS];
logic [31:0] lfsr = 32'he2dd9068;

aluop_e    exp_aluop;
alusel_e   exp_alusel;
word_t     exp_reg1;
word_t     exp_reg2;
reg_addr_t exp_wd;
logic      exp_wreg;
logic      exp_invalid;

// taps 32, 22, 2, 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        v    = {v[30:0], fb};
    end
    return v;
endfunction

function automatic dec_t special_entry(input logic [5:0] funct);
    case (funct)
        FN_AND:          return '{ALU_AND, SEL_LOGIC, WR_ALWAYS, 1'b1};
        FN_OR:           return '{ALU_OR, SEL_LOGIC, WR_ALWAYS, 1'b1};
        FN_XOR:          return '{ALU_XOR, SEL_LOGIC, WR_ALWAYS, 1'b1};
        FN_NOR:          return '{ALU_NOR, SEL_LOGIC, WR_ALWAYS, 1'b1};
        FN_SLL, FN_SLLV: return '{ALU_SLL, SEL_SHIFT, WR_ALWAYS, 1'b1};
        FN_SRL, FN_SRLV: return '{ALU_SRL, SEL_SHIFT, WR_ALWAYS, 1'b1};
        FN_SRA, FN_SRAV: return '{ALU_SRA, SEL_SHIFT, WR_ALWAYS, 1'b1};
        FN_ADD:          return '{ALU_ADD, SEL_ARITH, WR_ALWAYS, 1'b1};
        FN_ADDU:         return '{ALU_ADDU, SEL_ARITH, WR_ALWAYS, 1'b1};
        FN_SUB:          return '{ALU_SUB, SEL_ARITH, WR_ALWAYS, 1'b1};
        FN_SUBU:         return '{ALU_SUBU, SEL_ARITH, WR_ALWAYS, 1'b1};
        FN_SLT:          return '{ALU_SLT, SEL_ARITH, WR_ALWAYS, 1'b1};
        FN_SLTU:         return '{ALU_SLTU, SEL_ARITH, WR_ALWAYS, 1'b1};
        FN_MOVZ:         return '{ALU_MOVZ, SEL_MOVE, WR_IF_ZERO, 1'b1};
        FN_MOVN:         return '{ALU_MOVN, SEL_MOVE, WR_IF_NONZERO, 1'b1};
        default:         return '{ALU_NOP, SEL_NOP, WR_NONE, 1'b0};
    endcase
endfunction

function automatic dec_t imm_entry(input logic [5:0] op);
    case (op)
        OP_ANDI:        return '{ALU_AND, SEL_LOGIC, WR_ALWAYS, 1'b1};
        OP_ORI, OP_LUI: return '{ALU_OR, SEL_LOGIC, WR_ALWAYS, 1'b1};
        OP_XORI:        return '{ALU_XOR, SEL_LOGIC, WR_ALWAYS, 1'b1};
        OP_SLTI:        return '{ALU_SLT, SEL_ARITH, WR_ALWAYS, 1'b1};
        OP_SLTIU:       return '{ALU_SLTU, SEL_ARITH, WR_ALWAYS, 1'b1};
        OP_ADDI:        return '{ALU_ADDI, SEL_ARITH, WR_ALWAYS, 1'b1};
        OP_ADDIU:       return '{ALU_ADDIU, SEL_ARITH, WR_ALWAYS, 1'b1};
        default:        return '{ALU_NOP, SEL_NOP, WR_NONE, 1'b0};
    endcase
endfunction

function automatic word_t extend_imm(input logic [5:0] op, input logic [15:0] imm);
    case (op)
        OP_LUI:                     return {imm, 16'h0000};
        OP_ADDI, OP_ADDIU, OP_SLTI: return {{16{imm[15]}}, imm};
        default:                    return {16'h0000, imm};
    endcase
endfunction

// ex, then mem, then same-cycle write-back, then stored value
function automatic word_t source_value(input reg_addr_t a);
    if (a == '0) begin
        return '0;
    end else if (ex_wreg && ex_wd == a) begin
        return ex_wdata;
    end else if (mem_wreg && mem_wd == a) begin
        return mem_wdata;
    end else if (wb_we && wb_addr == a) begin
        return wb_data;
    end
    return shadow_rf[a];
endfunction

task automatic predict(input inst_u w);
    dec_t  d;
    logic  is_fixed;
    logic  re1;
    logic  re2;
    word_t imm;
    if (w.r_fmt.op == OP_SPECIAL) begin
        d        = special_entry(w.r_fmt.funct);
        is_fixed = w.r_fmt.funct inside {FN_SLL, FN_SRL, FN_SRA};
        re1      = !is_fixed;
        re2      = 1'b1;
        imm      = is_fixed ? word_t'(w.r_fmt.shamt) : '0;
        exp_wd   = w.r_fmt.rd;
    end else begin
        d      = imm_entry(w.i_fmt.op);
        re1    = 1'b1;
        re2    = 1'b0;  // port 2 slot carries the immediate
        imm    = extend_imm(w.i_fmt.op, w.i_fmt.imm16);
        exp_wd = w.i_fmt.rt;
    end
    if (!d.known) begin
        re1 = 1'b0;
        re2 = 1'b0;
        imm = '0;
    end
    exp_aluop   = d.op;
    exp_alusel  = d.sel;
    exp_invalid = !d.known;
    exp_reg1    = re1 ? source_value(w.r_fmt.rs) : imm;
    exp_reg2    = re2 ? source_value(w.r_fmt.rt) : imm;
    case (d.mode)
        WR_ALWAYS:     exp_wreg = 1'b1;
        WR_IF_ZERO:    exp_wreg = (exp_reg2 == '0);
        WR_IF_NONZERO: exp_wreg = (exp_reg2 != '0);
        default:       exp_wreg = 1'b0;
    endcase
endtask

function automatic void commit_writeback();
    if (wb_we && wb_addr != '0) begin
        shadow_rf[wb_addr] = wb_data;
    end
endfunction

// ==== testbench/tb_decode_top.sv ====
`timescale 1ns/1ps

module tb_decode_top;
    import isa_pkg::*;
    import pipe_pkg::*;

    logic      clk;
    logic      rst_n;
    logic      inst_valid;
    inst_u     inst;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      ex_wreg;
    reg_addr_t ex_wd;
    word_t     ex_wdata;
    logic      mem_wreg;
    reg_addr_t mem_wd;
    word_t     mem_wdata;
    logic      out_valid;
    aluop_e    aluop;
    alusel_e   alusel;
    word_t     reg1;
    word_t     reg2;
    reg_addr_t wd;
    logic      wreg;
    logic      inst_invalid;

    int n_tests;
    int n_checks;
    int n_errors;
    int test_errors;

    funct_e     alu_fns [10] = '{FN_AND, FN_OR, FN_XOR, FN_NOR, FN_ADD,
                                 FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU};
    funct_e     shift_fns [6] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
    op_e        imm_ops [8] = '{OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
                                OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU};
    // mfhi mthi mflo mtlo mult multu sync, plus one unused code
    logic [5:0] dropped_fns [8] = '{6'h10, 6'h11, 6'h12, 6'h13, 6'h18, 6'h19, 6'h0f, 6'h3f};

    `include "decode_model.svh"

    decode_top u_decode_top (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .inst_valid_i   (inst_valid),
        .inst_i         (inst),
        .wb_we_i        (wb_we),
        .wb_addr_i      (wb_addr),
        .wb_data_i      (wb_data),
        .ex_wreg_i      (ex_wreg),
        .ex_wd_i        (ex_wd),
        .ex_wdata_i     (ex_wdata),
        .mem_wreg_i     (mem_wreg),
        .mem_wd_i       (mem_wd),
        .mem_wdata_i    (mem_wdata),
        .out_valid_o    (out_valid),
        .aluop_o        (aluop),
        .alusel_o       (alusel),
        .reg1_o         (reg1),
        .reg2_o         (reg2),
        .wd_o           (wd),
        .wreg_o         (wreg),
        .inst_invalid_o (inst_invalid)
    );

    always #20 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        n_checks++;
        assert (act_v === exp_v) else begin
            $display("error: %0t ns %s expected %h actual %h", $time, name, exp_v, act_v);
            test_errors++;
        end
    endtask

    task automatic idle_inputs();
        inst_valid = 1'b0;
        inst       = '0;
        wb_we      = 1'b0;
        wb_addr    = '0;
        wb_data    = '0;
        ex_wreg    = 1'b0;
        ex_wd      = '0;
        ex_wdata   = '0;
        mem_wreg   = 1'b0;
        mem_wd     = '0;
        mem_wdata  = '0;
    endtask

    function automatic word_t rand_data();
        if (rand_bits(2) == 0) begin
            return '0;  // zero often, for movz and movn
        end
        return rand_bits(32);
    endfunction

    // narrow address widths give frequent matches
    task automatic randomize_sides(input int aw);
        ex_wreg   = 1'(rand_bits(1));
        ex_wd     = 5'(rand_bits(aw));
        ex_wdata  = rand_data();
        mem_wreg  = 1'(rand_bits(1));
        mem_wd    = 5'(rand_bits(aw));
        mem_wdata = rand_data();
        wb_we     = 1'(rand_bits(1));
        wb_addr   = 5'(rand_bits(aw));
        wb_data   = rand_data();
    endtask

    function automatic inst_u r_word(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [4:0] sh,
                                     input logic [5:0] fn);
        inst_u w;
        w.r_fmt = '{6'b000000, rs, rt, rd, sh, fn};
        return w;
    endfunction

    function automatic inst_u i_word(input logic [5:0] op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        inst_u w;
        w.i_fmt = '{op, rs, rt, imm};
        return w;
    endfunction

    task automatic send(input inst_u w);
        inst       = w;
        inst_valid = 1'b1;
        predict(w);
    endtask

    task automatic clock_step();
        @(posedge clk);
        commit_writeback();  // rf takes the write on this edge
        #2;
        idle_inputs();
    endtask

    task automatic check_out();
        int waited;
        waited = 0;
        while (!out_valid && waited < 10) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!out_valid) begin
            $display("timeout: out_valid_o stayed low for 10 cycles after a strobe");
            $display("tests failed");
            $finish;
        end else begin
            n_checks++;
            assert (waited == 0) else begin
                $display("out_valid_o arrived %0d cycles late", waited);
                test_errors++;
            end
            check_val("aluop_o", exp_aluop, aluop);
            check_val("alusel_o", exp_alusel, alusel);
            check_val("reg1_o", exp_reg1, reg1);
            check_val("reg2_o", exp_reg2, reg2);
            check_val("wreg_o", exp_wreg, wreg);
            check_val("inst_invalid_o", exp_invalid, inst_invalid);
            if (!exp_invalid) begin
                check_val("wd_o", exp_wd, wd);
            end
        end
    endtask

    task automatic expect_drop();
        clock_step();
        n_checks++;
        assert (!out_valid) else begin
            $display("out_valid_o stayed high a second cycle after a single strobe");
            test_errors++;
        end
    endtask

    task automatic start_test();
        n_tests++;
        test_errors = 0;
    endtask

    task automatic finish_test(input string name);
        $display("test %0d %s: %s", n_tests, name, (test_errors == 0) ? "ok" : "FAILED");
        n_errors += test_errors;
    endtask

    initial begin
        reg_addr_t  ra;
        reg_addr_t  rb;
        reg_addr_t  rc;
        logic [4:0] sh;
        logic [5:0] op;
        int         k;
        clk      = 1'b0;
        rst_n    = 1'b0;
        n_tests  = 0;
        n_checks = 0;
        n_errors = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow_rf[i] = '0;
        end
        idle_inputs();
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        start_test();
        check_val("out_valid_o", 1'b0, out_valid);
        check_val("wreg_o", 1'b0, wreg);
        for (int i = 0; i < 16; i++) begin
            wb_we   = 1'b1;
            wb_addr = 5'(rand_bits(5));
            wb_data = rand_bits(32);
            clock_step();
            ra = (i % 4 == 0) ? 5'd0 : 5'(rand_bits(5));
            rb = 5'(rand_bits(5));
            send(i_word(OP_ORI, ra, rb, 16'h0000));
            clock_step();
            check_out();
            expect_drop();
        end
        finish_test("register reads");

        start_test();
        for (int i = 0; i < 24; i++) begin
            randomize_sides(5);
            k  = int'(rand_bits(3));
            ra = 5'(rand_bits(5));
            rb = 5'(rand_bits(5));
            send(i_word(imm_ops[k], ra, rb, 16'(rand_bits(16))));
            clock_step();
            check_out();
            expect_drop();
        end
        finish_test("immediates");

        start_test();
        for (int i = 0; i < 32; i++) begin
            randomize_sides(2);
            ra = 5'(rand_bits(2));
            rb = 5'(rand_bits(2));
            rc = 5'(rand_bits(5));
            k  = int'(rand_bits(4)) % 10;
            send(r_word(ra, rb, rc, 5'd0, alu_fns[k]));
            clock_step();
            check_out();
            expect_drop();
        end
        finish_test("forwarding priority");

        start_test();
        for (int i = 0; i < 32; i++) begin
            randomize_sides(2);
            ra = 5'(rand_bits(2));
            rb = 5'(rand_bits(2));
            rc = 5'(rand_bits(5));
            k  = int'(rand_bits(1));
            send(r_word(ra, rb, rc, 5'd0, (k == 1) ? FN_MOVN : FN_MOVZ));
            clock_step();
            check_out();
            expect_drop();
        end
        finish_test("conditional moves");

        start_test();
        for (int i = 0; i < 24; i++) begin
            randomize_sides(5);
            k = int'(rand_bits(3)) % 6;
            if (k < 3) begin
                ra = '0;  // fixed shift, rs field must be zero
                sh = 5'(rand_bits(5));
            end else begin
                ra = 5'(rand_bits(5));
                sh = '0;
            end
            rb = 5'(rand_bits(5));
            rc = 5'(rand_bits(5));
            send(r_word(ra, rb, rc, sh, shift_fns[k]));
            clock_step();
            check_out();
            expect_drop();
        end
        finish_test("shifts");

        start_test();
        for (int i = 0; i < 24; i++) begin
            randomize_sides(5);
            ra = 5'(rand_bits(5));
            rb = 5'(rand_bits(5));
            if (i % 2 == 0) begin
                op = 6'(rand_bits(6));
                if (op == 6'h00 || op inside {[6'h08:6'h0f]}) begin
                    op = op | 6'h10;  // push kept opcodes into unused space
                end
                send(i_word(op, ra, rb, 16'(rand_bits(16))));
            end else begin
                rc = 5'(rand_bits(5));
                k  = int'(rand_bits(3));
                send(r_word(ra, rb, rc, 5'd0, dropped_fns[k]));
            end
            clock_step();
            check_out();
        end
        expect_drop();
        finish_test("invalid words back to back");

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+testbench
design/isa_pkg.sv
design/pipe_pkg.sv
design/rf_read_if.sv
design/regfile.sv
design/inst_decoder.sv
design/operand_fwd.sv
design/decode_top.sv
testbench/tb_decode_top.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - files:
      - design/isa_pkg.sv
      - design/pipe_pkg.sv
      - design/rf_read_if.sv
      - design/regfile.sv
      - design/inst_decoder.sv
      - design/operand_fwd.sv
      - design/decode_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_decode_top.sv
